// File: rtl/issue_pkg.sv
// --------------------
// issue stage shared definitions
// unit indices, widths, row state and payload types
// --------------------
package issue_pkg;

    // one status row per function unit
    localparam int NUM_FU = 5;
    localparam int FU_W   = 3;

    // unit indices double as bit positions in the wait masks
    localparam logic [FU_W-1:0] FU_ALU   = 3'd0;
    localparam logic [FU_W-1:0] FU_LDST  = 3'd1;
    localparam logic [FU_W-1:0] FU_BR    = 3'd2;
    localparam logic [FU_W-1:0] FU_MLDST = 3'd3;
    localparam logic [FU_W-1:0] FU_GEMM  = 3'd4;

    // scalar rows come first, matrix rows follow
    localparam int NUM_SROWS = 3;
    localparam int NUM_MROWS = 2;

    // saturating age counter
    localparam int AGE_W = 3;

    // scalar register file
    localparam int REG_W    = 5;
    localparam int NUM_REGS = 32;
    localparam int DATA_W   = 32;

    // matrix register index
    localparam int MREG_W = 4;

    typedef enum logic [1:0] {
        FUST_EMPTY,
        FUST_WAIT,
        FUST_EX
    } fust_state_e;

    typedef struct packed {
        logic [3:0]       op;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic [REG_W-1:0] rd;
    } fust_s_row_t;

    typedef struct packed {
        logic [3:0]        op;
        logic [MREG_W-1:0] ms1;
        logic [MREG_W-1:0] ms2;
        logic [MREG_W-1:0] ms3;
    } fust_m_row_t;

endpackage

// File: rtl/fust_if.sv
// --------------------
// status bank to issue selector link
// --------------------
interface fust_if #(
    parameter type ROW_T  = logic,
    parameter int  N_ROWS = 1
);

    // per-row view published by the bank
    logic [N_ROWS-1:0]            rdy;
    logic [issue_pkg::AGE_W-1:0]  age [N_ROWS];
    ROW_T                         payload [N_ROWS];
    issue_pkg::fust_state_e       state [N_ROWS];

    // one-hot issue strobe back from the selector
    logic [N_ROWS-1:0]            grant;

    modport bank (
        output rdy, age, payload, state,
        input  grant
    );

    modport sel (
        input  rdy, age, payload, state,
        output grant
    );

endinterface

// File: rtl/fust_bank.sv
// --------------------
// function-unit status bank
// per-row state, wait mask, age and payload
// --------------------
module fust_bank #(
    parameter type ROW_T  = logic,
    parameter int  N_ROWS = 1,
    parameter int  BASE   = 0
) (
    input  logic                         CLK,
    input  logic                         nRST,
    input  logic                         disp_en,
    input  logic [issue_pkg::FU_W-1:0]   disp_fu,
    input  logic [issue_pkg::NUM_FU-1:0] disp_mask,
    input  ROW_T                         disp_row,
    input  logic                         wb_en,
    input  logic [issue_pkg::FU_W-1:0]   wb_fu,
    fust_if.bank                         tbl
);

    issue_pkg::fust_state_e         state_q [N_ROWS];
    logic [issue_pkg::NUM_FU-1:0]   mask_q [N_ROWS];
    logic [issue_pkg::AGE_W-1:0]    age_q [N_ROWS];
    ROW_T                           payload_q [N_ROWS];

    logic [issue_pkg::FU_W-1:0]     disp_idx;
    logic [issue_pkg::FU_W-1:0]     wb_idx;
    logic                           disp_hit;
    logic                           wb_hit;
    logic [issue_pkg::NUM_FU-1:0]   wb_clr;
    logic [N_ROWS-1:0]              load_vec;
    logic [N_ROWS-1:0]              rel_vec;
    logic [N_ROWS-1:0]              empty_vec;
    logic [N_ROWS-1:0]              ex_vec;

    always_comb begin
        // units below BASE wrap to large indices and miss the range check
        disp_idx = disp_fu - issue_pkg::FU_W'(BASE);
        wb_idx   = wb_fu - issue_pkg::FU_W'(BASE);
        disp_hit = disp_en && (disp_idx < issue_pkg::FU_W'(N_ROWS));
        wb_hit   = wb_en && (wb_idx < issue_pkg::FU_W'(N_ROWS));
        wb_clr   = wb_en ? (issue_pkg::NUM_FU'(1) << wb_fu) : '0;
        for (int r = 0; r < N_ROWS; r++) begin
            load_vec[r]    = disp_hit && (disp_idx == issue_pkg::FU_W'(r));
            rel_vec[r]     = wb_hit && (wb_idx == issue_pkg::FU_W'(r));
            empty_vec[r]   = state_q[r] == issue_pkg::FUST_EMPTY;
            ex_vec[r]      = state_q[r] == issue_pkg::FUST_EX;
            tbl.rdy[r]     = (state_q[r] == issue_pkg::FUST_WAIT) && (mask_q[r] == '0);
            tbl.state[r]   = state_q[r];
            tbl.age[r]     = age_q[r];
            tbl.payload[r] = payload_q[r];
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int r = 0; r < N_ROWS; r++) begin
                state_q[r] <= issue_pkg::FUST_EMPTY;
                mask_q[r]  <= '0;
                age_q[r]   <= '0;
            end
        end else begin
            for (int r = 0; r < N_ROWS; r++) begin
                if (load_vec[r]) begin
                    // writeback on the same edge already clears its bit
                    state_q[r] <= issue_pkg::FUST_WAIT;
                    mask_q[r]  <= disp_mask & ~wb_clr;
                    age_q[r]   <= issue_pkg::AGE_W'(1);
                end else begin
                    mask_q[r] <= mask_q[r] & ~wb_clr;
                    if (rel_vec[r]) begin
                        state_q[r] <= issue_pkg::FUST_EMPTY;
                        age_q[r]   <= '0;
                    end else if (tbl.grant[r]) begin
                        state_q[r] <= issue_pkg::FUST_EX;
                    end else if (disp_en && !empty_vec[r] && (age_q[r] != '1)) begin
                        age_q[r] <= age_q[r] + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        for (int r = 0; r < N_ROWS; r++) begin
            if (load_vec[r]) begin
                payload_q[r] <= disp_row;
            end
        end
    end

    a_grant_onehot: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0(tbl.grant));

    a_disp_empty: assert property (@(posedge CLK) disable iff (!nRST)
        disp_hit |-> ((load_vec & ~empty_vec) == '0));

    a_release_ex: assert property (@(posedge CLK) disable iff (!nRST)
        wb_hit |-> ((rel_vec & ~ex_vec) == '0));

endmodule

// File: rtl/regfile.sv
// --------------------
// scalar register file
// two read ports, one write port, write-first bypass
// --------------------
module regfile (
    input  logic                         CLK,
    input  logic                         nRST,
    input  logic                         wen,
    input  logic [issue_pkg::REG_W-1:0]  wsel,
    input  logic [issue_pkg::DATA_W-1:0] wdata,
    input  logic [issue_pkg::REG_W-1:0]  rsel1,
    input  logic [issue_pkg::REG_W-1:0]  rsel2,
    output logic [issue_pkg::DATA_W-1:0] rdat1,
    output logic [issue_pkg::DATA_W-1:0] rdat2
);

    logic [issue_pkg::DATA_W-1:0] regs [issue_pkg::NUM_REGS];

    // register 0 is never written
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < issue_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (wsel != '0)) begin
            regs[wsel] <= wdata;
        end
    end

    // a write in the same cycle is seen by the read
    always_comb begin
        rdat1 = regs[rsel1];
        rdat2 = regs[rsel2];
        if (rsel1 == '0) begin
            rdat1 = '0;
        end else if (wen && (wsel == rsel1)) begin
            rdat1 = wdata;
        end
        if (rsel2 == '0) begin
            rdat2 = '0;
        end else if (wen && (wsel == rsel2)) begin
            rdat2 = wdata;
        end
    end

endmodule

// File: rtl/issue_select.sv
// --------------------
// oldest-ready issue arbiter
// register read and issue output register
// --------------------
module issue_select (
    input  logic                         CLK,
    input  logic                         nRST,
    input  logic                         freeze,
    fust_if.sel                          stbl,
    fust_if.sel                          mtbl,
    output logic [issue_pkg::REG_W-1:0]  rsel1,
    output logic [issue_pkg::REG_W-1:0]  rsel2,
    input  logic [issue_pkg::DATA_W-1:0] rdat1,
    input  logic [issue_pkg::DATA_W-1:0] rdat2,
    output logic                         iss_valid,
    output logic [issue_pkg::FU_W-1:0]   iss_fu,
    output logic [issue_pkg::REG_W-1:0]  iss_rd,
    output logic [issue_pkg::DATA_W-1:0] iss_rdat1,
    output logic [issue_pkg::DATA_W-1:0] iss_rdat2,
    output logic [issue_pkg::MREG_W-1:0] iss_ms1,
    output logic [issue_pkg::MREG_W-1:0] iss_ms2,
    output logic [issue_pkg::MREG_W-1:0] iss_ms3
);

    logic [issue_pkg::NUM_FU-1:0]  rdy_all;
    logic [issue_pkg::NUM_FU-1:0]  ex_all;
    logic [issue_pkg::NUM_FU-1:0]  win;
    logic [issue_pkg::AGE_W-1:0]   age_all [issue_pkg::NUM_FU];
    logic [issue_pkg::AGE_W-1:0]   best_age;
    logic [issue_pkg::FU_W-1:0]    win_fu;
    logic                          any_rdy;
    logic                          win_scalar;
    issue_pkg::fust_s_row_t        s_row;
    issue_pkg::fust_m_row_t        m_row;

    // flatten both banks into unit order
    always_comb begin
        for (int r = 0; r < issue_pkg::NUM_SROWS; r++) begin
            rdy_all[r] = stbl.rdy[r];
            age_all[r] = stbl.age[r];
            ex_all[r]  = stbl.state[r] == issue_pkg::FUST_EX;
        end
        for (int r = 0; r < issue_pkg::NUM_MROWS; r++) begin
            rdy_all[issue_pkg::NUM_SROWS+r] = mtbl.rdy[r];
            age_all[issue_pkg::NUM_SROWS+r] = mtbl.age[r];
            ex_all[issue_pkg::NUM_SROWS+r]  = mtbl.state[r] == issue_pkg::FUST_EX;
        end
    end

    // strict compare keeps the lower index on a tie
    always_comb begin
        any_rdy  = 1'b0;
        best_age = '0;
        win_fu   = '0;
        for (int i = 0; i < issue_pkg::NUM_FU; i++) begin
            if (rdy_all[i] && (!any_rdy || (age_all[i] > best_age))) begin
                any_rdy  = 1'b1;
                best_age = age_all[i];
                win_fu   = issue_pkg::FU_W'(i);
            end
        end
        win        = any_rdy ? (issue_pkg::NUM_FU'(1) << win_fu) : '0;
        stbl.grant = freeze ? '0 : win[issue_pkg::NUM_SROWS-1:0];
        mtbl.grant = freeze ? '0 : win[issue_pkg::NUM_FU-1:issue_pkg::NUM_SROWS];
    end

    // payload of the winning row
    always_comb begin
        s_row      = '0;
        m_row      = '0;
        win_scalar = 1'b0;
        for (int r = 0; r < issue_pkg::NUM_SROWS; r++) begin
            if (win[r]) begin
                s_row      = stbl.payload[r];
                win_scalar = 1'b1;
            end
        end
        for (int r = 0; r < issue_pkg::NUM_MROWS; r++) begin
            if (win[issue_pkg::NUM_SROWS+r]) begin
                m_row = mtbl.payload[r];
            end
        end
        rsel1 = s_row.rs1;
        rsel2 = s_row.rs2;
    end

    // bundle holds while frozen
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            iss_valid <= 1'b0;
            iss_fu    <= '0;
            iss_rd    <= '0;
            iss_rdat1 <= '0;
            iss_rdat2 <= '0;
            iss_ms1   <= '0;
            iss_ms2   <= '0;
            iss_ms3   <= '0;
        end else if (!freeze) begin
            iss_valid <= any_rdy;
            iss_fu    <= win_fu;
            iss_rd    <= s_row.rd;
            iss_rdat1 <= win_scalar ? rdat1 : '0;
            iss_rdat2 <= win_scalar ? rdat2 : '0;
            iss_ms1   <= m_row.ms1;
            iss_ms2   <= m_row.ms2;
            iss_ms3   <= m_row.ms3;
        end
    end

    // a valid after an unfrozen cycle belongs to the one row that just entered EX
    a_valid_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        !freeze |=> (!iss_valid
            || ((ex_all & ~$past(ex_all)) == (issue_pkg::NUM_FU'(1) << iss_fu))));

    // the issued unit's row has moved to EX in its bank
    a_issued_in_ex: assert property (@(posedge CLK) disable iff (!nRST)
        (!freeze && any_rdy) |=> (iss_valid && ex_all[iss_fu]));

endmodule

// File: rtl/issue_stage.sv
// --------------------
// issue stage top
// --------------------
module issue_stage (
    input  logic                         CLK,
    input  logic                         nRST,
    input  logic                         freeze,
    input  logic                         disp_en,
    input  logic [issue_pkg::FU_W-1:0]   disp_fu,
    input  logic [issue_pkg::NUM_FU-1:0] disp_mask,
    input  issue_pkg::fust_s_row_t       disp_srow,
    input  issue_pkg::fust_m_row_t       disp_mrow,
    input  logic                         wb_en,
    input  logic [issue_pkg::FU_W-1:0]   wb_fu,
    input  logic                         wb_wen,
    input  logic [issue_pkg::REG_W-1:0]  wb_rd,
    input  logic [issue_pkg::DATA_W-1:0] wb_data,
    output logic                         iss_valid,
    output logic [issue_pkg::FU_W-1:0]   iss_fu,
    output logic [issue_pkg::REG_W-1:0]  iss_rd,
    output logic [issue_pkg::DATA_W-1:0] iss_rdat1,
    output logic [issue_pkg::DATA_W-1:0] iss_rdat2,
    output logic [issue_pkg::MREG_W-1:0] iss_ms1,
    output logic [issue_pkg::MREG_W-1:0] iss_ms2,
    output logic [issue_pkg::MREG_W-1:0] iss_ms3
);

    logic [issue_pkg::REG_W-1:0]  rsel1;
    logic [issue_pkg::REG_W-1:0]  rsel2;
    logic [issue_pkg::DATA_W-1:0] rdat1;
    logic [issue_pkg::DATA_W-1:0] rdat2;

    fust_if #(.ROW_T(issue_pkg::fust_s_row_t), .N_ROWS(issue_pkg::NUM_SROWS)) s_tbl ();
    fust_if #(.ROW_T(issue_pkg::fust_m_row_t), .N_ROWS(issue_pkg::NUM_MROWS)) m_tbl ();

    // scalar units ALU, LDST, BR
    fust_bank #(
        .ROW_T  (issue_pkg::fust_s_row_t),
        .N_ROWS (issue_pkg::NUM_SROWS),
        .BASE   (int'(issue_pkg::FU_ALU))
    ) sbank_i (
        .CLK(CLK), .nRST(nRST),
        .disp_en(disp_en), .disp_fu(disp_fu), .disp_mask(disp_mask), .disp_row(disp_srow),
        .wb_en(wb_en), .wb_fu(wb_fu), .tbl(s_tbl)
    );

    // matrix units MLDST, GEMM
    fust_bank #(
        .ROW_T  (issue_pkg::fust_m_row_t),
        .N_ROWS (issue_pkg::NUM_MROWS),
        .BASE   (int'(issue_pkg::FU_MLDST))
    ) mbank_i (
        .CLK(CLK), .nRST(nRST),
        .disp_en(disp_en), .disp_fu(disp_fu), .disp_mask(disp_mask), .disp_row(disp_mrow),
        .wb_en(wb_en), .wb_fu(wb_fu), .tbl(m_tbl)
    );

    regfile regfile_i (
        .CLK(CLK), .nRST(nRST),
        .wen(wb_wen), .wsel(wb_rd), .wdata(wb_data),
        .rsel1(rsel1), .rsel2(rsel2), .rdat1(rdat1), .rdat2(rdat2)
    );

    issue_select select_i (
        .CLK(CLK), .nRST(nRST), .freeze(freeze),
        .stbl(s_tbl), .mtbl(m_tbl),
        .rsel1(rsel1), .rsel2(rsel2), .rdat1(rdat1), .rdat2(rdat2),
        .iss_valid(iss_valid), .iss_fu(iss_fu), .iss_rd(iss_rd),
        .iss_rdat1(iss_rdat1), .iss_rdat2(iss_rdat2),
        .iss_ms1(iss_ms1), .iss_ms2(iss_ms2), .iss_ms3(iss_ms3)
    );

endmodule

// File: dv/issue_stage_tb.sv
// --------------------
// issue stage testbench
// random dispatch and writeback against a table model
// --------------------
module issue_stage_tb;

    logic                         CLK;
    logic                         nRST;
    logic                         freeze;
    logic                         disp_en;
    logic [issue_pkg::FU_W-1:0]   disp_fu;
    logic [issue_pkg::NUM_FU-1:0] disp_mask;
    issue_pkg::fust_s_row_t       disp_srow;
    issue_pkg::fust_m_row_t       disp_mrow;
    logic                         wb_en;
    logic [issue_pkg::FU_W-1:0]   wb_fu;
    logic                         wb_wen;
    logic [issue_pkg::REG_W-1:0]  wb_rd;
    logic [issue_pkg::DATA_W-1:0] wb_data;
    logic                         iss_valid;
    logic [issue_pkg::FU_W-1:0]   iss_fu;
    logic [issue_pkg::REG_W-1:0]  iss_rd;
    logic [issue_pkg::DATA_W-1:0] iss_rdat1;
    logic [issue_pkg::DATA_W-1:0] iss_rdat2;
    logic [issue_pkg::MREG_W-1:0] iss_ms1;
    logic [issue_pkg::MREG_W-1:0] iss_ms2;
    logic [issue_pkg::MREG_W-1:0] iss_ms3;

    // model of the five rows and the register file
    issue_pkg::fust_state_e       m_state [issue_pkg::NUM_FU];
    logic [issue_pkg::NUM_FU-1:0] m_mask [issue_pkg::NUM_FU];
    logic [issue_pkg::AGE_W-1:0]  m_age [issue_pkg::NUM_FU];
    issue_pkg::fust_s_row_t       m_srow [issue_pkg::NUM_FU];
    issue_pkg::fust_m_row_t       m_mrow [issue_pkg::NUM_FU];
    logic [issue_pkg::DATA_W-1:0] m_regs [issue_pkg::NUM_REGS];

    // expected issue bundle after the next edge
    logic                         exp_valid;
    logic [issue_pkg::FU_W-1:0]   exp_fu;
    logic [issue_pkg::REG_W-1:0]  exp_rd;
    logic [issue_pkg::DATA_W-1:0] exp_rdat1;
    logic [issue_pkg::DATA_W-1:0] exp_rdat2;
    logic [issue_pkg::MREG_W-1:0] exp_ms1;
    logic [issue_pkg::MREG_W-1:0] exp_ms2;
    logic [issue_pkg::MREG_W-1:0] exp_ms3;
    logic                         last_frz;

    integer seed;
    int     errors;
    int     n_disp;
    int     n_iss;
    int     wait_cnt;
    // rates out of 16 per cycle
    int     p_disp;
    int     p_wb;
    int     p_frz;

    issue_stage dut_i (.*);

    always #2 CLK = ~CLK;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // register 0 reads zero and a same-cycle write wins
    function automatic logic [31:0] reg_value(input logic [issue_pkg::REG_W-1:0] sel);
        if (sel == '0) begin
            return '0;
        end
        if (wb_wen && (wb_rd == sel)) begin
            return wb_data;
        end
        return m_regs[sel];
    endfunction

    function automatic logic table_empty();
        for (int i = 0; i < issue_pkg::NUM_FU; i++) begin
            if (m_state[i] != issue_pkg::FUST_EMPTY) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic check_outputs;
        compare_value("iss_valid", 32'(iss_valid), 32'(exp_valid));
        if (exp_valid) begin
            compare_value("iss_fu", 32'(iss_fu), 32'(exp_fu));
            compare_value("iss_rd", 32'(iss_rd), 32'(exp_rd));
            compare_value("iss_rdat1", iss_rdat1, exp_rdat1);
            compare_value("iss_rdat2", iss_rdat2, exp_rdat2);
            compare_value("iss_ms1", 32'(iss_ms1), 32'(exp_ms1));
            compare_value("iss_ms2", 32'(iss_ms2), 32'(exp_ms2));
            compare_value("iss_ms3", 32'(iss_ms3), 32'(exp_ms3));
        end
        // a held bundle under freeze is not a new issue
        if (iss_valid && !last_frz) begin
            n_iss++;
        end
    endtask

    task automatic pick_inputs;
        logic [31:0]                  rv;
        logic [31:0]                  rv2;
        logic [issue_pkg::NUM_FU-1:0] occ;
        int                           start;
        int                           idx;
        rv      = $random(seed);
        rv2     = $random(seed);
        freeze  = int'(rv[3:0]) < p_frz;
        disp_en = 1'b0;
        wb_en   = 1'b0;
        wb_wen  = 1'b0;
        for (int i = 0; i < issue_pkg::NUM_FU; i++) begin
            occ[i] = m_state[i] != issue_pkg::FUST_EMPTY;
        end
        // dispatch targets an empty row and waits only on occupied units
        if (int'(rv[7:4]) < p_disp) begin
            start = int'(rv[10:8]) % issue_pkg::NUM_FU;
            idx   = -1;
            for (int k = 0; k < issue_pkg::NUM_FU; k++) begin
                if (idx < 0
                        && m_state[(start + k) % issue_pkg::NUM_FU] == issue_pkg::FUST_EMPTY) begin
                    idx = (start + k) % issue_pkg::NUM_FU;
                end
            end
            if (idx >= 0) begin
                disp_en   = 1'b1;
                disp_fu   = 3'(idx);
                disp_mask = rv2[31] ? (rv2[4:0] & occ) : '0;
                disp_srow = rv2[23:5];
                disp_mrow = rv2[20:5];
            end
        end
        // writeback only for a unit in execute
        if (int'(rv[15:12]) < p_wb) begin
            start = int'(rv[18:16]) % issue_pkg::NUM_FU;
            for (int k = 0; k < issue_pkg::NUM_FU; k++) begin
                if (!wb_en
                        && m_state[(start + k) % issue_pkg::NUM_FU] == issue_pkg::FUST_EX) begin
                    wb_en = 1'b1;
                    wb_fu = 3'((start + k) % issue_pkg::NUM_FU);
                end
            end
            wb_wen  = wb_en && rv[19];
            wb_rd   = rv[24:20];
            wb_data = $random(seed);
        end
    endtask

    task automatic model_step;
        int                           win;
        logic [issue_pkg::NUM_FU-1:0] wb_clr;
        win = -1;
        // the oldest ready row wins and a tie keeps the lower unit
        for (int i = 0; i < issue_pkg::NUM_FU; i++) begin
            if (m_state[i] == issue_pkg::FUST_WAIT && m_mask[i] == '0) begin
                if (win < 0 || m_age[i] > m_age[win]) begin
                    win = i;
                end
            end
        end
        if (!freeze) begin
            exp_valid = win >= 0;
            exp_fu    = '0;
            exp_rd    = '0;
            exp_rdat1 = '0;
            exp_rdat2 = '0;
            exp_ms1   = '0;
            exp_ms2   = '0;
            exp_ms3   = '0;
            if (win >= 0) begin
                exp_fu = 3'(win);
            end
            if (win >= 0 && win < issue_pkg::NUM_SROWS) begin
                exp_rd    = m_srow[win].rd;
                exp_rdat1 = reg_value(m_srow[win].rs1);
                exp_rdat2 = reg_value(m_srow[win].rs2);
            end else if (win >= issue_pkg::NUM_SROWS) begin
                exp_ms1 = m_mrow[win].ms1;
                exp_ms2 = m_mrow[win].ms2;
                exp_ms3 = m_mrow[win].ms3;
            end
        end
        last_frz = freeze;
        wb_clr   = wb_en ? (5'(1) << wb_fu) : '0;
        for (int i = 0; i < issue_pkg::NUM_FU; i++) begin
            if (disp_en && int'(disp_fu) == i) begin
                m_state[i] = issue_pkg::FUST_WAIT;
                m_mask[i]  = disp_mask & ~wb_clr;
                m_age[i]   = 3'd1;
                m_srow[i]  = disp_srow;
                m_mrow[i]  = disp_mrow;
            end else begin
                m_mask[i] = m_mask[i] & ~wb_clr;
                if (wb_en && int'(wb_fu) == i) begin
                    m_state[i] = issue_pkg::FUST_EMPTY;
                    m_age[i]   = '0;
                end else if (!freeze && win == i) begin
                    m_state[i] = issue_pkg::FUST_EX;
                end else if (disp_en && m_state[i] != issue_pkg::FUST_EMPTY
                             && m_age[i] != 3'd7) begin
                    m_age[i] = m_age[i] + 3'd1;
                end
            end
        end
        if (wb_wen && wb_rd != '0) begin
            m_regs[wb_rd] = wb_data;
        end
        if (disp_en) begin
            n_disp++;
        end
    endtask

    task automatic run_cycles(input int n);
        repeat (n) begin
            pick_inputs();
            model_step();
            @(posedge CLK);
            #1;
            check_outputs();
        end
    endtask

    initial begin
        CLK       = 1'b0;
        nRST      = 1'b0;
        freeze    = 1'b0;
        disp_en   = 1'b0;
        disp_fu   = '0;
        disp_mask = '0;
        disp_srow = '0;
        disp_mrow = '0;
        wb_en     = 1'b0;
        wb_fu     = '0;
        wb_wen    = 1'b0;
        wb_rd     = '0;
        wb_data   = '0;
        seed      = 32'hbc4f301b;
        errors    = 0;
        n_disp    = 0;
        n_iss     = 0;
        exp_valid = 1'b0;
        last_frz  = 1'b0;
        for (int i = 0; i < issue_pkg::NUM_FU; i++) begin
            m_state[i] = issue_pkg::FUST_EMPTY;
            m_mask[i]  = '0;
            m_age[i]   = '0;
        end
        for (int i = 0; i < issue_pkg::NUM_REGS; i++) begin
            m_regs[i] = '0;
        end

        repeat (10) @(posedge CLK);
        #1;
        nRST = 1'b1;
        compare_value("iss_valid", 32'(iss_valid), 32'd0);

        // busy dispatch, then freeze pressure, then mixed traffic
        p_disp = 10;
        p_wb   = 6;
        p_frz  = 0;
        run_cycles(400);
        p_disp = 12;
        p_wb   = 8;
        p_frz  = 5;
        run_cycles(400);
        p_disp = 8;
        p_wb   = 8;
        p_frz  = 2;
        run_cycles(1200);

        // drain until every row is free again
        p_disp   = 0;
        p_wb     = 16;
        p_frz    = 0;
        wait_cnt = 0;
        while (!table_empty() && wait_cnt < 100) begin
            run_cycles(1);
            wait_cnt++;
        end
        if (!table_empty()) begin
            errors++;
            $display("Timeout: status table did not drain within 100 cycles");
        end
        run_cycles(2);
        compare_value("issue_count", 32'(n_iss), 32'(n_disp));

        $display("checks done: %0d errors, %0d dispatched, %0d issued", errors, n_disp, n_iss);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: issue_stage.f
rtl/issue_pkg.sv
rtl/fust_if.sv
rtl/fust_bank.sv
rtl/regfile.sv
rtl/issue_select.sv
rtl/issue_stage.sv
dv/issue_stage_tb.sv

// File: Makefile
# Verilator build for the issue stage testbench

VERILATOR ?= verilator
TOP       ?= issue_stage_tb
FLIST     ?= issue_stage.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_STR  ?= TEST RESULT: PASS

SIM = $(BUILD)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

run: compile
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STR)"

clean:
	rm -rf $(BUILD)
